//--- design/core_pkg.sv
package core_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [63:0] dword_t;
  // doubleword address, byte address bits 31..3
  typedef logic [28:0] isram_adr_t;
  typedef logic [3:0]  ben_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 codes of the kept instructions
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // addi x0, x0, 0
  localparam xlen_t NOP_INSTR = 32'h0000_0013;

endpackage

//--- design/de_ex_if.sv
`timescale 1ns/10ps

interface de_ex_if;

  logic                 valid;
  core_pkg::alu_op_e    alu_op;
  core_pkg::xlen_t      operand_a;
  core_pkg::xlen_t      operand_b;
  core_pkg::reg_idx_t   rd;
  logic                 wr_reg;
  logic                 is_store;
  core_pkg::xlen_t      store_data;
  logic                 is_branch;
  logic                 branch_ne;
  core_pkg::xlen_t      branch_target;

  modport decode (
    output valid, alu_op, operand_a, operand_b, rd, wr_reg,
    output is_store, store_data, is_branch, branch_ne, branch_target
  );

  modport execute (
    input valid, alu_op, operand_a, operand_b, rd, wr_reg,
    input is_store, store_data, is_branch, branch_ne, branch_target
  );

endinterface

//--- design/fetch.sv
`timescale 1ns/10ps

module fetch (
  input  logic                  clk,
  input  logic                  arst_n,
  input  core_pkg::xlen_t       boot_addr,
  input  core_pkg::dword_t      instr_fromsram,
  input  logic                  redirect,
  input  core_pkg::xlen_t       redirect_pc,
  output logic                  isram_cs,
  output core_pkg::isram_adr_t  isram_adr,
  output core_pkg::xlen_t       fetch_instr,
  output core_pkg::xlen_t       fetch_pc,
  output logic                  fetch_valid
);

  core_pkg::xlen_t pc;
  core_pkg::xlen_t req_pc;
  logic            req_valid;

  // first edge after reset starts at boot_addr, then sequential
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      isram_cs  <= 1'b0;
      pc        <= '0;
      req_valid <= 1'b0;
    end else begin
      isram_cs  <= 1'b1;
      // wrong-path request when a branch is taken
      req_valid <= isram_cs & ~redirect;
      if (!isram_cs) begin
        pc <= boot_addr;
      end else if (redirect) begin
        pc <= redirect_pc;
      end else begin
        pc <= pc + 32'd4;
      end
    end
  end

  // pc of the request the SRAM is answering
  always_ff @(posedge clk) begin
    req_pc <= pc;
  end

  assign isram_adr   = pc[31:3];
  assign fetch_instr = req_pc[2] ? instr_fromsram[63:32] : instr_fromsram[31:0];
  assign fetch_pc    = req_pc;
  assign fetch_valid = req_valid;

endmodule

//--- design/inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::xlen_t     fetch_instr,
  input  core_pkg::xlen_t     fetch_pc,
  input  logic                fetch_valid,
  input  logic                redirect,
  input  logic                wb_en,
  input  core_pkg::reg_idx_t  wb_idx,
  input  core_pkg::xlen_t     wb_data,
  input  core_pkg::xlen_t     rs1v,
  input  core_pkg::xlen_t     rs2v,
  output core_pkg::reg_idx_t  rs1_addr,
  output core_pkg::reg_idx_t  rs2_addr,
  de_ex_if.decode             de_ex
);

  core_pkg::xlen_t    instr;
  core_pkg::xlen_t    pc;
  logic               valid;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  core_pkg::xlen_t    imm_i;
  core_pkg::xlen_t    imm_s;
  core_pkg::xlen_t    imm_b;
  core_pkg::xlen_t    imm_u;
  core_pkg::xlen_t    rs1_val;
  core_pkg::xlen_t    rs2_val;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr <= core_pkg::NOP_INSTR;
      valid <= 1'b0;
    end else begin
      valid <= fetch_valid & ~redirect;
      instr <= (fetch_valid && !redirect) ? fetch_instr : core_pkg::NOP_INSTR;
    end
  end

  always_ff @(posedge clk) begin
    pc <= fetch_pc;
  end

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // result written in execute this cycle is not yet in the regfile
  assign rs1_val = (wb_en && wb_idx != '0 && wb_idx == rs1_addr) ? wb_data : rs1v;
  assign rs2_val = (wb_en && wb_idx != '0 && wb_idx == rs2_addr) ? wb_data : rs2v;

  always_comb begin
    de_ex.valid         = valid;
    de_ex.alu_op        = core_pkg::ALU_ADD;
    de_ex.operand_a     = rs1_val;
    de_ex.operand_b     = rs2_val;
    de_ex.rd            = instr[11:7];
    de_ex.wr_reg        = 1'b0;
    de_ex.is_store      = 1'b0;
    de_ex.store_data    = rs2_val;
    de_ex.is_branch     = 1'b0;
    de_ex.branch_ne     = (funct3 == core_pkg::F3_BNE);
    de_ex.branch_target = pc + imm_b;
    case (opcode)
      core_pkg::OPC_OP: begin
        de_ex.wr_reg = 1'b1;
        case (funct3)
          core_pkg::F3_ADD_SUB: de_ex.alu_op = instr[30] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          core_pkg::F3_XOR:     de_ex.alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:      de_ex.alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND:     de_ex.alu_op = core_pkg::ALU_AND;
          default:              de_ex.wr_reg = 1'b0;
        endcase
      end
      core_pkg::OPC_OP_IMM: begin
        // addi only
        de_ex.operand_b = imm_i;
        de_ex.wr_reg    = (funct3 == core_pkg::F3_ADD_SUB);
      end
      core_pkg::OPC_LUI: begin
        de_ex.operand_b = imm_u;
        de_ex.alu_op    = core_pkg::ALU_PASS_B;
        de_ex.wr_reg    = 1'b1;
      end
      core_pkg::OPC_STORE: begin
        de_ex.operand_b = imm_s;
        de_ex.is_store  = (funct3 == core_pkg::F3_SW);
      end
      core_pkg::OPC_BRANCH: begin
        de_ex.is_branch = (funct3 == core_pkg::F3_BEQ) || (funct3 == core_pkg::F3_BNE);
      end
      default: ;
    endcase
  end

endmodule

//--- design/regfile.sv
`timescale 1ns/10ps

module regfile (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::reg_idx_t  rs1_addr,
  input  core_pkg::reg_idx_t  rs2_addr,
  input  logic                wb_en,
  input  core_pkg::reg_idx_t  wb_idx,
  input  core_pkg::xlen_t     wb_data,
  output core_pkg::xlen_t     rs1v,
  output core_pkg::xlen_t     rs2v
);

  core_pkg::xlen_t regs [32];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_idx != '0) begin
      regs[wb_idx] <= wb_data;
    end
  end

  assign rs1v = regs[rs1_addr];
  assign rs2v = regs[rs2_addr];

endmodule

//--- design/inst_execute.sv
`timescale 1ns/10ps

module inst_execute (
  input  logic                clk,
  input  logic                arst_n,
  de_ex_if.execute            de_ex,
  output logic                wb_en,
  output core_pkg::reg_idx_t  wb_idx,
  output core_pkg::xlen_t     wb_data,
  output logic                redirect,
  output core_pkg::xlen_t     redirect_pc,
  output core_pkg::xlen_t     dsram_addr,
  output logic                dsram_cs,
  output logic                dsram_we,
  output core_pkg::ben_t      dsram_ben,
  output core_pkg::xlen_t     dsram_wdata
);

  logic                ex_valid;
  core_pkg::alu_op_e   ex_alu_op;
  core_pkg::xlen_t     ex_op_a;
  core_pkg::xlen_t     ex_op_b;
  core_pkg::reg_idx_t  ex_rd;
  logic                ex_wr_reg;
  logic                ex_is_store;
  core_pkg::xlen_t     ex_store_data;
  logic                ex_is_branch;
  logic                ex_branch_ne;
  core_pkg::xlen_t     ex_target;
  core_pkg::xlen_t     alu_res;

  // instruction behind a taken branch is dropped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= de_ex.valid & ~redirect;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_op     <= de_ex.alu_op;
    ex_op_a       <= de_ex.operand_a;
    ex_op_b       <= de_ex.operand_b;
    ex_rd         <= de_ex.rd;
    ex_wr_reg     <= de_ex.wr_reg;
    ex_is_store   <= de_ex.is_store;
    ex_store_data <= de_ex.store_data;
    ex_is_branch  <= de_ex.is_branch;
    ex_branch_ne  <= de_ex.branch_ne;
    ex_target     <= de_ex.branch_target;
  end

  always_comb begin
    case (ex_alu_op)
      core_pkg::ALU_SUB:    alu_res = ex_op_a - ex_op_b;
      core_pkg::ALU_AND:    alu_res = ex_op_a & ex_op_b;
      core_pkg::ALU_OR:     alu_res = ex_op_a | ex_op_b;
      core_pkg::ALU_XOR:    alu_res = ex_op_a ^ ex_op_b;
      core_pkg::ALU_PASS_B: alu_res = ex_op_b;
      default:              alu_res = ex_op_a + ex_op_b;
    endcase
  end

  // beq taken on equal, bne on not equal
  assign redirect    = ex_valid & ex_is_branch & ((ex_op_a == ex_op_b) ^ ex_branch_ne);
  assign redirect_pc = ex_target;

  assign wb_en   = ex_valid & ex_wr_reg;
  assign wb_idx  = ex_rd;
  assign wb_data = alu_res;

  // sw only, full word
  assign dsram_cs    = ex_valid & ex_is_store;
  assign dsram_we    = ex_valid & ex_is_store;
  assign dsram_ben   = '1;
  assign dsram_addr  = alu_res;
  assign dsram_wdata = ex_store_data;

endmodule

//--- design/core.sv
`timescale 1ns/10ps

module core (
  input  logic                  clk,
  input  logic                  arst_n,
  input  core_pkg::xlen_t       boot_addr,
  input  core_pkg::dword_t      instr_fromsram,
  output logic                  isram_cs,
  output core_pkg::isram_adr_t  isram_adr,
  output core_pkg::xlen_t       dsram_addr,
  output logic                  dsram_cs,
  output logic                  dsram_we,
  output core_pkg::ben_t        dsram_ben,
  output core_pkg::xlen_t       dsram_wdata
);

  core_pkg::xlen_t     fetch_instr;
  core_pkg::xlen_t     fetch_pc;
  logic                fetch_valid;
  logic                redirect;
  core_pkg::xlen_t     redirect_pc;
  logic                wb_en;
  core_pkg::reg_idx_t  wb_idx;
  core_pkg::xlen_t     wb_data;
  core_pkg::reg_idx_t  rs1_addr;
  core_pkg::reg_idx_t  rs2_addr;
  core_pkg::xlen_t     rs1v;
  core_pkg::xlen_t     rs2v;

  de_ex_if de_ex ();

  fetch fetch_u (
    .clk            (clk),
    .arst_n         (arst_n),
    .boot_addr      (boot_addr),
    .instr_fromsram (instr_fromsram),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .isram_cs       (isram_cs),
    .isram_adr      (isram_adr),
    .fetch_instr    (fetch_instr),
    .fetch_pc       (fetch_pc),
    .fetch_valid    (fetch_valid)
  );

  inst_decode inst_decode_u (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_instr (fetch_instr),
    .fetch_pc    (fetch_pc),
    .fetch_valid (fetch_valid),
    .redirect    (redirect),
    .wb_en       (wb_en),
    .wb_idx      (wb_idx),
    .wb_data     (wb_data),
    .rs1v        (rs1v),
    .rs2v        (rs2v),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .de_ex       (de_ex.decode)
  );

  regfile regfile_u (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wb_en    (wb_en),
    .wb_idx   (wb_idx),
    .wb_data  (wb_data),
    .rs1v     (rs1v),
    .rs2v     (rs2v)
  );

  inst_execute inst_execute_u (
    .clk         (clk),
    .arst_n      (arst_n),
    .de_ex       (de_ex.execute),
    .wb_en       (wb_en),
    .wb_idx      (wb_idx),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .dsram_addr  (dsram_addr),
    .dsram_cs    (dsram_cs),
    .dsram_we    (dsram_we),
    .dsram_ben   (dsram_ben),
    .dsram_wdata (dsram_wdata)
  );

endmodule

//--- test/tb_core.sv
`timescale 1ns/10ps

module tb_core;

  localparam logic [31:0] BOOT     = 32'h0000_0104;
  // address used only by stores on a skipped branch path
  localparam logic [11:0] SKIP_IMM = 12'h7fc;

  logic                  clk = 1'b0;
  logic                  arst_n;
  core_pkg::xlen_t       boot_addr;
  core_pkg::dword_t      instr_fromsram = '0;
  logic                  isram_cs;
  core_pkg::isram_adr_t  isram_adr;
  core_pkg::xlen_t       dsram_addr;
  logic                  dsram_cs;
  logic                  dsram_we;
  core_pkg::ben_t        dsram_ben;
  core_pkg::xlen_t       dsram_wdata;

  logic [31:0]           imem [1024];
  core_pkg::isram_adr_t  sram_adr_q = '0;
  logic [31:0]           lcg_state = 32'hcbda;
  logic [31:0]           exp_addr_q [$];
  logic [31:0]           exp_data_q [$];
  logic [31:0]           halt_pc;
  int                    wp;
  int                    steps;
  int                    total_stores;
  int                    store_count = 0;
  int                    limit_cycles = 0;

  core i_dut (.*);

  always #50 clk = ~clk;

  // instruction SRAM, reply one cycle after the request
  always @(posedge clk) begin
    if (isram_cs) begin
      sram_adr_q <= isram_adr;
    end
  end

  always @(negedge clk) begin
    instr_fromsram <= {imem[{sram_adr_q[8:0], 1'b1}], imem[{sram_adr_q[8:0], 1'b0}]};
  end

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_check(input string what);
    $display("Error at %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    stop_run();
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rr_op(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic emit(input logic [31:0] ins);
    imem[10'(wp)] = ins;
    wp++;
  endtask

  task automatic random_op(input logic [4:0] rd, input logic [4:0] rs1);
    logic [31:0] r;
    logic [4:0]  rs2;
    r   = next_rand();
    rs2 = 5'(1 + (r >> 20) % 15);
    case ((r >> 8) % 7)
      0: emit(addi(r[31:20], rs1, rd));
      1: emit(rr_op(7'h00, rs2, rs1, 3'b000, rd));
      2: emit(rr_op(7'h20, rs2, rs1, 3'b000, rd));
      3: emit(rr_op(7'h00, rs2, rs1, 3'b111, rd));
      4: emit(rr_op(7'h00, rs2, rs1, 3'b110, rd));
      5: emit(rr_op(7'h00, rs2, rs1, 3'b100, rd));
      default: emit(lui(r[27:8], rd));
    endcase
  endtask

  task automatic build_program();
    logic [4:0]  prev;
    logic [4:0]  rd_a;
    logic [4:0]  rd_b;
    logic [11:0] v;
    // unused words are addi x0 no-ops tagged with their index
    for (int i = 0; i < 1024; i++) begin
      imem[10'(i)] = {i[11:0], 13'd0, 7'b0010011};
    end
    wp   = int'(BOOT >> 2);
    prev = 5'd1;
    for (int k = 0; k < 8; k++) begin
      rd_a = 5'(1 + (next_rand() >> 12) % 15);
      rd_b = 5'(1 + (next_rand() >> 12) % 15);
      random_op(rd_a, prev);
      random_op(rd_b, rd_a);
      emit(store_word(12'(12'h100 + 8 * k), rd_a, 5'd0));
      emit(store_word(12'(12'h104 + 8 * k), rd_b, 5'd0));
      prev = rd_b;
    end
    v = 12'(next_rand() >> 4);
    emit(addi(v, 5'd0, 5'd16));
    emit(addi(v, 5'd0, 5'd17));
    // taken beq
    emit(branch(13'd12, 5'd17, 5'd16, 3'b000));
    emit(store_word(SKIP_IMM, 5'd16, 5'd0));
    emit(store_word(SKIP_IMM, 5'd17, 5'd0));
    emit(store_word(12'h200, 5'd16, 5'd0));
    emit(branch(13'd12, 5'd17, 5'd16, 3'b001));
    emit(store_word(12'h204, 5'd17, 5'd0));
    emit(addi(12'd1, 5'd16, 5'd18));
    // taken bne right behind the write of x18
    emit(branch(13'd12, 5'd18, 5'd16, 3'b001));
    emit(store_word(SKIP_IMM, 5'd16, 5'd0));
    emit(store_word(SKIP_IMM, 5'd18, 5'd0));
    emit(store_word(12'h208, 5'd18, 5'd0));
    emit(branch(13'd12, 5'd18, 5'd16, 3'b000));
    emit(store_word(12'h20c, 5'd16, 5'd0));
    // x0 writes must not reach the regfile or the bypass
    emit(rr_op(7'h00, 5'd17, 5'd16, 3'b000, 5'd0));
    emit(store_word(12'h210, 5'd0, 5'd0));
    emit(addi(12'h037, 5'd16, 5'd0));
    emit(store_word(12'h214, 5'd0, 5'd0));
    halt_pc = 32'(wp * 4);
    emit(branch(13'd0, 5'd0, 5'd0, 3'b000));
  endtask

  // ISA interpreter of the kept RV32 subset
  task automatic run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic        take;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc    = BOOT;
    steps = 0;
    while (pc != halt_pc && steps < 4096) begin
      ins  = imem[pc[11:2]];
      a    = regs[ins[19:15]];
      b    = regs[ins[24:20]];
      take = 1'b0;
      case (ins[6:0])
        7'b0110011: begin
          case (ins[14:12])
            3'b000: regs[ins[11:7]] = ins[30] ? a - b : a + b;
            3'b100: regs[ins[11:7]] = a ^ b;
            3'b110: regs[ins[11:7]] = a | b;
            3'b111: regs[ins[11:7]] = a & b;
            default: ;
          endcase
        end
        7'b0010011: begin
          if (ins[14:12] == 3'b000) begin
            regs[ins[11:7]] = a + {{20{ins[31]}}, ins[31:20]};
          end
        end
        7'b0110111: regs[ins[11:7]] = {ins[31:12], 12'd0};
        7'b0100011: begin
          if (ins[14:12] == 3'b010) begin
            exp_addr_q.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
            exp_data_q.push_back(b);
          end
        end
        7'b1100011: begin
          take = (ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b);
        end
        default: ;
      endcase
      regs[0] = '0;
      pc = take ? pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}
                : pc + 32'd4;
      steps++;
    end
    if (pc != halt_pc) begin
      fail_check("reference model never reached the halt loop");
    end
  endtask

  a_reset_idle: assert property (@(posedge clk) !arst_n |-> (!isram_cs && !dsram_cs && !dsram_we))
    else fail_check("SRAM strobes active during reset");

  a_store_we: assert property (@(posedge clk) disable iff (!arst_n) dsram_cs == dsram_we)
    else value_mismatch("dsram_we", 32'($sampled(dsram_we)), 32'($sampled(dsram_cs)));

  a_store_ben: assert property (@(posedge clk) disable iff (!arst_n)
      dsram_cs |-> dsram_ben == 4'hf)
    else value_mismatch("dsram_ben", 32'($sampled(dsram_ben)), 32'hf);

  // one store per cycle with dsram_cs, in program order
  always @(negedge clk) begin
    if (arst_n && dsram_cs) begin
      if (exp_addr_q.size() == 0) begin
        fail_check("store seen after all expected stores");
      end else begin
        assert (dsram_addr != 32'(SKIP_IMM))
          else fail_check("store from a skipped branch path");
        assert (dsram_addr == exp_addr_q[0])
          else value_mismatch("dsram_addr", dsram_addr, exp_addr_q[0]);
        assert (dsram_wdata == exp_data_q[0])
          else value_mismatch("dsram_wdata", dsram_wdata, exp_data_q[0]);
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
        store_count++;
      end
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    fail_check("watchdog expired before the program finished");
  end

  initial begin
    arst_n    = 1'b0;
    boot_addr = BOOT;
    build_program();
    run_reference();
    total_stores = exp_addr_q.size();
    limit_cycles = 4 * (10 + 3 * steps + 10);
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    assert (!isram_cs && !dsram_cs && !dsram_we)
      else fail_check("SRAM strobes active right after reset release");
    @(negedge clk);
    assert (isram_cs) else fail_check("no instruction request after reset release");
    assert (isram_adr == BOOT[31:3])
      else value_mismatch("isram_adr", 32'(isram_adr), 32'(BOOT[31:3]));
    wait (store_count == total_stores);
    // the halt loop keeps spinning, any extra store would show up here
    repeat (10) @(posedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule

//--- files.f
design/core_pkg.sv
design/de_ex_if.sv
design/fetch.sv
design/inst_decode.sv
design/regfile.sv
design/inst_execute.sv
design/core.sv
test/tb_core.sv

//--- Makefile
SRCS := $(shell cat files.f)

obj_dir/Vtb_core: files.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_core -f files.f

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core

clean:
	rm -rf obj_dir

.PHONY: run clean
